//--- iqDefs_defs.svh
/*
 * Issue queue sizing macros
 * Entry count, index and pointer widths, lane counts, sequence lengths
 */

`ifndef IQ_DEFS_SVH
`define IQ_DEFS_SVH

// Queue geometry
`define IQ_ENTRY_NUM    16
`define IQ_INDEX_WIDTH  4
`define IQ_COUNT_WIDTH  5

// Lane counts
`define DISPATCH_WIDTH  2
`define ISSUE_WIDTH     2
`define RETURN_WIDTH    4

// Recovery sequence lengths in cycles
`define RETURN_CYCLES   (`IQ_ENTRY_NUM / `RETURN_WIDTH)
`define RESET_CYCLES    16

`define AL_PTR_WIDTH    5

`endif

//--- iqPkg.sv
/*
 * Issue queue types: entry index, active-list pointer,
 * integer and memory payloads, flush range check
 */

`include "iqDefs_defs.svh"

package iqPkg;

    typedef logic [`IQ_INDEX_WIDTH-1:0] iqIndex;
    typedef logic [`AL_PTR_WIDTH-1:0] alPtr;

    // Integer pipe payload, 22 bits
    typedef struct packed {
        logic [3:0] opCode;
        logic [5:0] dstReg;
        logic [5:0] srcRegA;
        logic [5:0] srcRegB;
    } intEntry;

    // Memory pipe payload, 25 bits
    typedef struct packed {
        logic        isStore;
        logic [5:0]  addrReg;
        logic [5:0]  dataReg;
        logic [11:0] offset;
    } memEntry;

    // Circular range [head, tail), empty when head equals tail
    function automatic logic inFlushRange(
        input alPtr head,
        input alPtr tail,
        input logic flushAll,
        input alPtr ptr
    );
        logic inRange;
        if (head < tail) begin
            inRange = (ptr >= head) && (ptr < tail);
        end else if (head > tail) begin
            inRange = (ptr >= head) || (ptr < tail);
        end else begin
            inRange = 1'b0;
        end
        return flushAll || inRange;
    endfunction

endpackage

//--- multiWidthFreeList.sv
/*
 * Circular free list of entry indices
 * Several pop lanes, compacted push lanes, clear back to full
 */

`timescale 1ns/1ps
`include "iqDefs_defs.svh"

module multiWidthFreeList #(
    parameter int SIZE       = `IQ_ENTRY_NUM,
    parameter int POP_WIDTH  = `DISPATCH_WIDTH,
    parameter int PUSH_WIDTH = `ISSUE_WIDTH + `RETURN_WIDTH
) (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           clear,
    input  logic                           pop,
    output iqPkg::iqIndex [POP_WIDTH-1:0]  poppedData,
    input  logic [PUSH_WIDTH-1:0]          push,
    input  iqPkg::iqIndex [PUSH_WIDTH-1:0] pushedData,
    output logic [`IQ_COUNT_WIDTH-1:0]     count
);

    localparam int PTR_WIDTH = $clog2(SIZE);
    localparam int CNT_WIDTH = `IQ_COUNT_WIDTH;

    iqPkg::iqIndex        mem [SIZE];
    logic [PTR_WIDTH-1:0] headPtr;
    logic [PTR_WIDTH-1:0] tailPtr;
    logic                 popValid;
    logic [PTR_WIDTH-1:0] pushSlot [PUSH_WIDTH];
    logic [CNT_WIDTH-1:0] pushNum;

    // Pointer advance with wrap at SIZE
    function automatic logic [PTR_WIDTH-1:0] wrapAdd(
        input logic [PTR_WIDTH-1:0] ptr,
        input int unsigned          step
    );
        int unsigned sum;
        sum = ptr + step;
        return PTR_WIDTH'(sum % SIZE);
    endfunction

    // Pop only when a full group of indices is available
    always_comb begin
        popValid = pop && (count >= CNT_WIDTH'(POP_WIDTH));
        for (int i = 0; i < POP_WIDTH; i++) begin
            poppedData[i] = mem[wrapAdd(headPtr, i)];
        end
    end

    // Valid push lanes land on consecutive slots from the tail, lane order kept
    always_comb begin
        pushNum = '0;
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            pushSlot[i] = wrapAdd(tailPtr, pushNum);
            if (push[i]) begin
                pushNum = pushNum + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= CNT_WIDTH'(SIZE);
            for (int i = 0; i < SIZE; i++) begin
                mem[i] <= iqPkg::iqIndex'(i);
            end
        end else if (clear) begin
            // Refill in ascending order, all entries free
            headPtr <= '0;
            tailPtr <= '0;
            count   <= CNT_WIDTH'(SIZE);
            for (int i = 0; i < SIZE; i++) begin
                mem[i] <= iqPkg::iqIndex'(i);
            end
        end else begin
            for (int i = 0; i < PUSH_WIDTH; i++) begin
                if (push[i]) begin
                    mem[pushSlot[i]] <= pushedData[i];
                end
            end
            if (popValid) begin
                headPtr <= wrapAdd(headPtr, POP_WIDTH);
            end
            tailPtr <= wrapAdd(tailPtr, pushNum);
            count   <= count + pushNum - (popValid ? CNT_WIDTH'(POP_WIDTH) : '0);
        end
    end

endmodule

//--- payloadRam.sv
/*
 * Multi-port distributed payload RAM
 * Clocked writes, combinational reads, payload type as a parameter
 */

`timescale 1ns/1ps
`include "iqDefs_defs.svh"

module payloadRam #(
    parameter type entryType = iqPkg::intEntry,
    parameter int  ENTRY_NUM = `IQ_ENTRY_NUM,
    parameter int  READ_NUM  = `ISSUE_WIDTH,
    parameter int  WRITE_NUM = `DISPATCH_WIDTH
) (
    input  logic                          clk,
    input  logic [WRITE_NUM-1:0]          we,
    input  iqPkg::iqIndex [WRITE_NUM-1:0] wa,
    input  entryType [WRITE_NUM-1:0]      wv,
    input  iqPkg::iqIndex [READ_NUM-1:0]  ra,
    output entryType [READ_NUM-1:0]       rv
);

    entryType mem [ENTRY_NUM];

    // Higher lane wins when two lanes hit the same entry
    always_ff @(posedge clk) begin
        for (int i = 0; i < WRITE_NUM; i++) begin
            if (we[i]) begin
                mem[wa[i]] <= wv[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < READ_NUM; i++) begin
            rv[i] = mem[ra[i]];
        end
    end

endmodule

//--- flushReturnUnit.sv
/*
 * Selective flush for the issue queue
 * Per-entry active-list pointer copy, flush detection,
 * sequencer returning flushed indices to the free list
 */

`timescale 1ns/1ps
`include "iqDefs_defs.svh"

module flushReturnUnit (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic [`DISPATCH_WIDTH-1:0]          write,
    input  iqPkg::iqIndex [`DISPATCH_WIDTH-1:0] writePtr,
    input  iqPkg::alPtr [`DISPATCH_WIDTH-1:0]   writeAlPtr,
    input  logic [`DISPATCH_WIDTH-1:0]          allocated,
    input  logic                                toRecoveryPhase,
    input  logic                                recoveryFromRw,
    input  iqPkg::alPtr                         flushRangeHead,
    input  iqPkg::alPtr                         flushRangeTail,
    input  logic                                flushAllInsns,
    input  logic [`IQ_ENTRY_NUM-1:0]            notIssued,
    input  iqPkg::iqIndex [`ISSUE_WIDTH-1:0]    selectedPtr,
    output iqPkg::alPtr [`ISSUE_WIDTH-1:0]      selectedAlPtr,
    output logic [`IQ_ENTRY_NUM-1:0]            flushEntry,
    output logic [`RETURN_WIDTH-1:0]            returnEntry,
    output iqPkg::iqIndex [`RETURN_WIDTH-1:0]   returnPtr,
    output logic                                returning
);

    localparam int CYCLE_WIDTH = $clog2(`RETURN_CYCLES + 1);
    localparam iqPkg::iqIndex RETURN_STEP = `RETURN_WIDTH;

    iqPkg::alPtr              alPtrReg [`IQ_ENTRY_NUM];
    logic [`IQ_ENTRY_NUM-1:0] flushCaptured;
    iqPkg::iqIndex            returnOffset;
    logic [CYCLE_WIDTH-1:0]   returnCycle;
    logic                     startReturn;

    // Copy of each entry's active-list pointer, taken at dispatch
    always_ff @(posedge clk) begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (write[i]) begin
                alPtrReg[writePtr[i]] <= writeAlPtr[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            selectedAlPtr[i] = alPtrReg[selectedPtr[i]];
        end
    end

    always_comb begin
        for (int i = 0; i < `IQ_ENTRY_NUM; i++) begin
            flushEntry[i] = notIssued[i] && toRecoveryPhase &&
                iqPkg::inFlushRange(flushRangeHead, flushRangeTail, flushAllInsns, alPtrReg[i]);
        end
        // Ops in dispatch hold an entry but are not yet marked notIssued
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (allocated[i]) begin
                flushEntry[writePtr[i]] = toRecoveryPhase &&
                    iqPkg::inFlushRange(flushRangeHead, flushRangeTail, flushAllInsns,
                                        writeAlPtr[i]);
            end
        end
    end

    assign startReturn = toRecoveryPhase && recoveryFromRw;

    // One window of RETURN_WIDTH indices per cycle
    always_comb begin
        for (int i = 0; i < `RETURN_WIDTH; i++) begin
            returnPtr[i]   = returnOffset + iqPkg::iqIndex'(i);
            returnEntry[i] = returning && flushCaptured[returnPtr[i]];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flushCaptured <= '0;
            returning     <= 1'b0;
            returnCycle   <= '0;
            returnOffset  <= '0;
        end else if (startReturn) begin
            flushCaptured <= flushEntry;
            returning     <= 1'b1;
            returnCycle   <= '0;
            returnOffset  <= '0;
        end else if (returning) begin
            returnOffset <= returnOffset + RETURN_STEP;
            if (returnCycle == CYCLE_WIDTH'(`RETURN_CYCLES - 1)) begin
                returning   <= 1'b0;
                returnCycle <= '0;
            end else begin
                returnCycle <= returnCycle + 1'b1;
            end
        end
    end

endmodule

//--- issueQueue.sv
/*
 * Issue queue top: free list, integer and memory payload RAMs,
 * selective flush unit, commit-recovery rebuild of the free list
 */

`timescale 1ns/1ps
`include "iqDefs_defs.svh"

module issueQueue (
    input  logic                                 clk,
    input  logic                                 arstN,
    // Allocation
    input  logic                                 allocate,
    output logic                                 allocatable,
    output iqPkg::iqIndex [`DISPATCH_WIDTH-1:0]  allocatedPtr,
    // Dispatch
    input  logic [`DISPATCH_WIDTH-1:0]           write,
    input  iqPkg::iqIndex [`DISPATCH_WIDTH-1:0]  writePtr,
    input  iqPkg::alPtr [`DISPATCH_WIDTH-1:0]    writeAlPtr,
    input  iqPkg::intEntry [`DISPATCH_WIDTH-1:0] intWriteData,
    input  iqPkg::memEntry [`DISPATCH_WIDTH-1:0] memWriteData,
    // Issue and release
    input  iqPkg::iqIndex [`ISSUE_WIDTH-1:0]     intIssuePtr,
    output iqPkg::intEntry [`ISSUE_WIDTH-1:0]    intIssuedData,
    input  iqPkg::iqIndex [`ISSUE_WIDTH-1:0]     memIssuePtr,
    output iqPkg::memEntry [`ISSUE_WIDTH-1:0]    memIssuedData,
    input  logic [`ISSUE_WIDTH-1:0]              releaseEntry,
    input  iqPkg::iqIndex [`ISSUE_WIDTH-1:0]     releasePtr,
    input  iqPkg::iqIndex [`ISSUE_WIDTH-1:0]     selectedPtr,
    output iqPkg::alPtr [`ISSUE_WIDTH-1:0]       selectedAlPtr,
    // Recovery
    input  logic                                 toRecoveryPhase,
    input  logic                                 recoveryFromRw,
    input  iqPkg::alPtr                          flushRangeHead,
    input  iqPkg::alPtr                          flushRangeTail,
    input  logic                                 flushAllInsns,
    input  logic [`IQ_ENTRY_NUM-1:0]             notIssued,
    input  logic [`DISPATCH_WIDTH-1:0]           allocated,
    output logic [`IQ_ENTRY_NUM-1:0]             flushEntry,
    output logic                                 returningIndex
);

    localparam int PUSH_NUM        = `ISSUE_WIDTH + `RETURN_WIDTH;
    localparam int CNT_WIDTH       = `IQ_COUNT_WIDTH;
    localparam int REBUILD_WIDTH   = $clog2(`RESET_CYCLES + 1);

    logic [CNT_WIDTH-1:0]           freeListCount;
    logic                           rebuilding;
    logic [REBUILD_WIDTH-1:0]       rebuildCycle;
    logic [`RETURN_WIDTH-1:0]       returnEntry;
    iqPkg::iqIndex [`RETURN_WIDTH-1:0] returnPtr;
    logic                           returning;
    logic [PUSH_NUM-1:0]            pushEntry;
    iqPkg::iqIndex [PUSH_NUM-1:0]   pushPtr;

    // Issue lanes take the low push lanes, return lanes follow
    assign pushEntry = {returnEntry, releaseEntry};
    assign pushPtr   = {returnPtr, releasePtr};

    // Block allocation while the list is being rebuilt
    assign allocatable    = !rebuilding && (freeListCount >= CNT_WIDTH'(`DISPATCH_WIDTH));
    assign returningIndex = returning || rebuilding;

    multiWidthFreeList #(
        .SIZE      (`IQ_ENTRY_NUM),
        .POP_WIDTH (`DISPATCH_WIDTH),
        .PUSH_WIDTH(PUSH_NUM)
    ) freeList (
        .clk       (clk),
        .arstN     (arstN),
        .clear     (rebuilding),
        .pop       (allocate),
        .poppedData(allocatedPtr),
        .push      (pushEntry),
        .pushedData(pushPtr),
        .count     (freeListCount)
    );

    payloadRam #(
        .entryType(iqPkg::intEntry),
        .ENTRY_NUM(`IQ_ENTRY_NUM),
        .READ_NUM (`ISSUE_WIDTH),
        .WRITE_NUM(`DISPATCH_WIDTH)
    ) intRam (
        .clk(clk),
        .we (write),
        .wa (writePtr),
        .wv (intWriteData),
        .ra (intIssuePtr),
        .rv (intIssuedData)
    );

    payloadRam #(
        .entryType(iqPkg::memEntry),
        .ENTRY_NUM(`IQ_ENTRY_NUM),
        .READ_NUM (`ISSUE_WIDTH),
        .WRITE_NUM(`DISPATCH_WIDTH)
    ) memRam (
        .clk(clk),
        .we (write),
        .wa (writePtr),
        .wv (memWriteData),
        .ra (memIssuePtr),
        .rv (memIssuedData)
    );

    flushReturnUnit flushUnit (
        .clk            (clk),
        .arstN          (arstN),
        .write          (write),
        .writePtr       (writePtr),
        .writeAlPtr     (writeAlPtr),
        .allocated      (allocated),
        .toRecoveryPhase(toRecoveryPhase),
        .recoveryFromRw (recoveryFromRw),
        .flushRangeHead (flushRangeHead),
        .flushRangeTail (flushRangeTail),
        .flushAllInsns  (flushAllInsns),
        .notIssued      (notIssued),
        .selectedPtr    (selectedPtr),
        .selectedAlPtr  (selectedAlPtr),
        .flushEntry     (flushEntry),
        .returnEntry    (returnEntry),
        .returnPtr      (returnPtr),
        .returning      (returning)
    );

    // Commit recovery holds the free list in clear for RESET_CYCLES cycles
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rebuilding   <= 1'b0;
            rebuildCycle <= '0;
        end else if (toRecoveryPhase && !recoveryFromRw) begin
            rebuilding   <= 1'b1;
            rebuildCycle <= '0;
        end else if (rebuilding) begin
            if (rebuildCycle == REBUILD_WIDTH'(`RESET_CYCLES - 1)) begin
                rebuilding   <= 1'b0;
                rebuildCycle <= '0;
            end else begin
                rebuildCycle <= rebuildCycle + 1'b1;
            end
        end
    end

endmodule

//--- tbIssueQueue.sv
/*
 * Testbench for the issue queue
 * Reads commands from iqStim.txt, models the free list, both payload RAMs
 * and the active-list pointers, checks allocation, reads, flush and recovery
 */

`timescale 1ns/1ps
`include "iqDefs_defs.svh"

module tbIssueQueue;

    localparam int    CLK_PERIOD      = 20;
    localparam int    RESET_LEN       = 8;
    localparam int    CYCLES_PER_LINE = 40;
    localparam int    INT_BITS        = $bits(iqPkg::intEntry);
    localparam int    MEM_BITS        = $bits(iqPkg::memEntry);
    localparam string STIM_FILE       = "iqStim.txt";

    logic                                 clk;
    logic                                 arstN;
    logic                                 allocate;
    logic                                 allocatable;
    iqPkg::iqIndex [`DISPATCH_WIDTH-1:0]  allocatedPtr;
    logic [`DISPATCH_WIDTH-1:0]           write;
    iqPkg::iqIndex [`DISPATCH_WIDTH-1:0]  writePtr;
    iqPkg::alPtr [`DISPATCH_WIDTH-1:0]    writeAlPtr;
    iqPkg::intEntry [`DISPATCH_WIDTH-1:0] intWriteData;
    iqPkg::memEntry [`DISPATCH_WIDTH-1:0] memWriteData;
    iqPkg::iqIndex [`ISSUE_WIDTH-1:0]     intIssuePtr;
    iqPkg::intEntry [`ISSUE_WIDTH-1:0]    intIssuedData;
    iqPkg::iqIndex [`ISSUE_WIDTH-1:0]     memIssuePtr;
    iqPkg::memEntry [`ISSUE_WIDTH-1:0]    memIssuedData;
    logic [`ISSUE_WIDTH-1:0]              releaseEntry;
    iqPkg::iqIndex [`ISSUE_WIDTH-1:0]     releasePtr;
    iqPkg::iqIndex [`ISSUE_WIDTH-1:0]     selectedPtr;
    iqPkg::alPtr [`ISSUE_WIDTH-1:0]       selectedAlPtr;
    logic                                 toRecoveryPhase;
    logic                                 recoveryFromRw;
    iqPkg::alPtr                          flushRangeHead;
    iqPkg::alPtr                          flushRangeTail;
    logic                                 flushAllInsns;
    logic [`IQ_ENTRY_NUM-1:0]             notIssued;
    logic [`DISPATCH_WIDTH-1:0]           allocated;
    logic [`IQ_ENTRY_NUM-1:0]             flushEntry;
    logic                                 returningIndex;

    // Reference models
    iqPkg::iqIndex  freeQ [$];
    iqPkg::intEntry intModel [`IQ_ENTRY_NUM];
    iqPkg::memEntry memModel [`IQ_ENTRY_NUM];
    iqPkg::alPtr    alModel [`IQ_ENTRY_NUM];

    // Hex fields of the current stim line
    logic [31:0]    field [11];

    issueQueue i_issueQueue (
        .clk            (clk),
        .arstN          (arstN),
        .allocate       (allocate),
        .allocatable    (allocatable),
        .allocatedPtr   (allocatedPtr),
        .write          (write),
        .writePtr       (writePtr),
        .writeAlPtr     (writeAlPtr),
        .intWriteData   (intWriteData),
        .memWriteData   (memWriteData),
        .intIssuePtr    (intIssuePtr),
        .intIssuedData  (intIssuedData),
        .memIssuePtr    (memIssuePtr),
        .memIssuedData  (memIssuedData),
        .releaseEntry   (releaseEntry),
        .releasePtr     (releasePtr),
        .selectedPtr    (selectedPtr),
        .selectedAlPtr  (selectedAlPtr),
        .toRecoveryPhase(toRecoveryPhase),
        .recoveryFromRw (recoveryFromRw),
        .flushRangeHead (flushRangeHead),
        .flushRangeTail (flushRangeTail),
        .flushAllInsns  (flushAllInsns),
        .notIssued      (notIssued),
        .allocated      (allocated),
        .flushEntry     (flushEntry),
        .returningIndex (returningIndex)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic checkValue(input string name, input logic [63:0] expVal,
                              input logic [63:0] actVal);
        assert (actVal === expVal) else begin
            $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expVal, actVal);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic requireFields(input int got, input int want);
        if (got != want) begin
            failRun($sformatf("Stim line has %0d fields where %0d are needed", got, want));
        end
    endtask

    // Strobes drop back to idle at every edge unless a command raises them
    task automatic nextCycle();
        @(posedge clk);
        allocate        <= 1'b0;
        write           <= '0;
        releaseEntry    <= '0;
        toRecoveryPhase <= 1'b0;
        allocated       <= '0;
    endtask

    task automatic refillFreeModel();
        freeQ.delete();
        for (int i = 0; i < `IQ_ENTRY_NUM; i++) begin
            freeQ.push_back(iqPkg::iqIndex'(i));
        end
    endtask

    task automatic doAllocate(input int times);
        logic expAlloc;
        repeat (times) begin
            nextCycle();
            expAlloc = (freeQ.size() >= `DISPATCH_WIDTH);
            if (expAlloc) begin
                allocate <= 1'b1;
            end
            @(negedge clk);
            checkValue("allocatable", 64'(expAlloc), 64'(allocatable));
            if (expAlloc) begin
                for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                    checkValue($sformatf("allocatedPtr[%0d]", i), 64'(freeQ[i]),
                               64'(allocatedPtr[i]));
                end
                repeat (`DISPATCH_WIDTH) void'(freeQ.pop_front());
            end
        end
    endtask

    task automatic doWrite();
        nextCycle();
        write <= field[0][`DISPATCH_WIDTH-1:0];
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            writePtr[i]     <= field[1 + i][`IQ_INDEX_WIDTH-1:0];
            writeAlPtr[i]   <= field[3 + i][`AL_PTR_WIDTH-1:0];
            intWriteData[i] <= field[5 + i][INT_BITS-1:0];
            memWriteData[i] <= field[7 + i][MEM_BITS-1:0];
            // Later lane wins on a shared entry
            if (field[0][i]) begin
                intModel[field[1 + i][`IQ_INDEX_WIDTH-1:0]] = field[5 + i][INT_BITS-1:0];
                memModel[field[1 + i][`IQ_INDEX_WIDTH-1:0]] = field[7 + i][MEM_BITS-1:0];
                alModel[field[1 + i][`IQ_INDEX_WIDTH-1:0]]  = field[3 + i][`AL_PTR_WIDTH-1:0];
            end
        end
    endtask

    task automatic doRead();
        nextCycle();
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            intIssuePtr[i] <= field[i][`IQ_INDEX_WIDTH-1:0];
            selectedPtr[i] <= field[i][`IQ_INDEX_WIDTH-1:0];
            memIssuePtr[i] <= field[2 + i][`IQ_INDEX_WIDTH-1:0];
        end
        @(negedge clk);
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            checkValue($sformatf("intIssuedData[%0d]", i),
                       64'(intModel[field[i][`IQ_INDEX_WIDTH-1:0]]), 64'(intIssuedData[i]));
            checkValue($sformatf("memIssuedData[%0d]", i),
                       64'(memModel[field[2 + i][`IQ_INDEX_WIDTH-1:0]]), 64'(memIssuedData[i]));
            checkValue($sformatf("selectedAlPtr[%0d]", i),
                       64'(alModel[field[i][`IQ_INDEX_WIDTH-1:0]]), 64'(selectedAlPtr[i]));
        end
    endtask

    task automatic doRelease();
        nextCycle();
        releaseEntry <= field[0][`ISSUE_WIDTH-1:0];
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            releasePtr[i] <= field[1 + i][`IQ_INDEX_WIDTH-1:0];
            if (field[0][i]) begin
                freeQ.push_back(field[1 + i][`IQ_INDEX_WIDTH-1:0]);
            end
        end
    endtask

    task automatic doFlush();
        logic [`IQ_ENTRY_NUM-1:0] expFlush;
        expFlush = field[10][`IQ_ENTRY_NUM-1:0];
        nextCycle();
        toRecoveryPhase <= 1'b1;
        recoveryFromRw  <= field[0][0];
        flushRangeHead  <= field[1][`AL_PTR_WIDTH-1:0];
        flushRangeTail  <= field[2][`AL_PTR_WIDTH-1:0];
        flushAllInsns   <= field[3][0];
        notIssued       <= field[4][`IQ_ENTRY_NUM-1:0];
        allocated       <= field[5][`DISPATCH_WIDTH-1:0];
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            writePtr[i]   <= field[6 + i][`IQ_INDEX_WIDTH-1:0];
            writeAlPtr[i] <= field[8 + i][`AL_PTR_WIDTH-1:0];
        end
        @(negedge clk);
        checkValue("flushEntry", 64'(expFlush), 64'(flushEntry));
        if (field[0][0]) begin
            // Return windows, one per cycle
            repeat (`RETURN_CYCLES) begin
                nextCycle();
                @(negedge clk);
                checkValue("returningIndex", 64'(1), 64'(returningIndex));
            end
            nextCycle();
            @(negedge clk);
            checkValue("returningIndex", 64'(0), 64'(returningIndex));
            for (int i = 0; i < `IQ_ENTRY_NUM; i++) begin
                if (expFlush[i]) begin
                    freeQ.push_back(iqPkg::iqIndex'(i));
                end
            end
        end else begin
            repeat (`RESET_CYCLES) begin
                nextCycle();
                @(negedge clk);
                checkValue("allocatable", 64'(0), 64'(allocatable));
                checkValue("returningIndex", 64'(1), 64'(returningIndex));
            end
            nextCycle();
            @(negedge clk);
            checkValue("allocatable", 64'(1), 64'(allocatable));
            checkValue("returningIndex", 64'(0), 64'(returningIndex));
            refillFreeModel();
        end
    endtask

    initial begin
        int                 fd;
        int                 got;
        logic [63:0]        word;
        logic [8*160-1:0]   lineBuf;
        clk             = 1'b0;
        arstN           = 1'b0;
        allocate        = 1'b0;
        write           = '0;
        writePtr        = '0;
        writeAlPtr      = '0;
        intWriteData    = '0;
        memWriteData    = '0;
        intIssuePtr     = '0;
        memIssuePtr     = '0;
        releaseEntry    = '0;
        releasePtr      = '0;
        selectedPtr     = '0;
        toRecoveryPhase = 1'b0;
        recoveryFromRw  = 1'b0;
        flushRangeHead  = '0;
        flushRangeTail  = '0;
        flushAllInsns   = 1'b0;
        notIssued       = '0;
        allocated       = '0;
        refillFreeModel();
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            failRun("Could not open the stim file");
        end
        repeat (RESET_LEN) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkValue("allocatable", 64'(1), 64'(allocatable));
        checkValue("returningIndex", 64'(0), 64'(returningIndex));
        while ($fscanf(fd, "%s", word) == 1) begin
            case (word)
                "#": got = $fgets(lineBuf, fd);
                "A": begin
                    got = $fscanf(fd, "%h", field[0]);
                    requireFields(got, 1);
                    doAllocate(int'(field[0]));
                end
                "W": begin
                    got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", field[0], field[1],
                                  field[2], field[3], field[4], field[5], field[6],
                                  field[7], field[8]);
                    requireFields(got, 9);
                    doWrite();
                end
                "R": begin
                    got = $fscanf(fd, "%h %h %h %h", field[0], field[1], field[2], field[3]);
                    requireFields(got, 4);
                    doRead();
                end
                "L": begin
                    got = $fscanf(fd, "%h %h %h", field[0], field[1], field[2]);
                    requireFields(got, 3);
                    doRelease();
                end
                "F": begin
                    got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", field[0],
                                  field[1], field[2], field[3], field[4], field[5],
                                  field[6], field[7], field[8], field[9], field[10]);
                    requireFields(got, 11);
                    doFlush();
                end
                "N": begin
                    got = $fscanf(fd, "%h", field[0]);
                    requireFields(got, 1);
                    repeat (int'(field[0])) nextCycle();
                end
                default: failRun($sformatf("Unknown stim command %0s", word));
            endcase
        end
        $fclose(fd);
        $display("STATUS: PASS");
        $finish;
    end

    // Watchdog sized from the stim length
    initial begin
        int               fd;
        int               lines;
        logic [8*160-1:0] countBuf;
        lines = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while ($fgets(countBuf, fd) != 0) begin
                lines++;
            end
            $fclose(fd);
        end
        #((lines * CYCLES_PER_LINE + RESET_LEN) * CLK_PERIOD);
        $display("Timeout: the stim commands did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- iqStim.txt
# Hex columns: A count | W mask ptr0 ptr1 al0 al1 int0 int1 mem0 mem1 | R int0 int1 mem0 mem1
# L mask ptr0 ptr1 | N count | F rfw head tail all notIssued alloc wp0 wp1 wal0 wal1 flushEntry
# Full list after reset is handed out in order, then runs dry
A 8
A 1
N 2
# Payloads and active-list pointers for entries 0 to 7
W 3 0 1 00 01 0a1234 1fffff 0000001 1abcdef
W 3 2 3 02 03 2b5678 000000 1234567 0fedcba
W 3 4 5 1c 1d 3c9abc 155555 0aaaaaa 1555555
W 3 6 7 1e 1f 3fffff 2aaaaa 1ffffff 0000000
R 0 1 2 3
R 4 5 6 7
R 7 6 1 0
# Entry 3 rewritten through lane 1 only
W 2 0 3 00 03 000000 123456 0000000 1010101
R 3 0 3 7
R 2 3 4 3
N 1
# Issue lanes release, lane 0 ahead of lane 1
L 3 5 2
L 1 9 0
L 2 0 c
A 2
A 1
L 3 e 1
N 1
A 1
A 1
# Register-write recovery, wrapped range, dispatch lane 0 flushed
F 1 1e 02 0 00ff 1 9 a 1f 00 02c3
A 2
A 1
# Commit recovery with an empty range
F 0 03 03 0 00ff 3 2 b 05 10 0000
# Commit recovery, plain range, dispatch lane clears entry 4
F 0 01 1d 0 00f7 1 4 0 00 00 0006
# Commit recovery with flush-all
F 0 05 05 1 0055 2 0 c 00 07 1055
# Rebuilt list comes out in order again
A 8
A 1
R 0 7 3 5
N 3

//--- verilog.f
+incdir+.
iqPkg.sv
multiWidthFreeList.sv
payloadRam.sv
flushReturnUnit.sv
issueQueue.sv
tbIssueQueue.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tbIssueQueue
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the issue queue testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
